/* sa_defs.svh */
`ifndef SA_DEFS_SVH
`define SA_DEFS_SVH

////////////////////////////////////////////////////////////
// array geometry
////////////////////////////////////////////////////////////

`define SA_N 4          // rows and columns
`define ROW_W 2         // row index, log2 of SA_N

////////////////////////////////////////////////////////////
// operand and lane widths
////////////////////////////////////////////////////////////

`define PIX_W 8         // unsigned pixel
`define ACC88_W 32      // int8 x uint8 lane
`define ACC18_W 16      // binary weight lane
`define ACC_W 64        // one accumulator word per pe

// readout flow control
`define OUT_CREDITS 2

`endif

/* sa_data_pkg.sv */
`include "sa_defs.svh"

package sa_data_pkg;

    // two pixels per column per cycle, pixel 0 in the low byte
    typedef logic [1:0][`PIX_W-1:0] pix_pair_t;

    // one weight byte per row per cycle
    // mode 0: signed int8, mode 1: bit 0 and bit 1 are binary weights
    typedef logic [7:0] wgt_byte_t;

    ////////////////////////////////////////////////////////////
    // accumulator word, decoded by mode
    ////////////////////////////////////////////////////////////

    // l88[p] : lane for pixel p (mode 0)
    // l18[2*w + p] : lane for weight bit w and pixel p (mode 1)
    typedef union packed {
        logic [1:0][`ACC88_W-1:0] l88;
        logic [3:0][`ACC18_W-1:0] l18;
    } acc_word_u;

endpackage

/* sa_ctrl_pkg.sv */
package sa_ctrl_pkg;

    // weight decoding, latched while reset is high
    typedef enum logic {
        MODE_8X8 = 1'b0,    // signed int8 weight
        MODE_8X1 = 1'b1     // two +1/-1 weights
    } sa_mode_e;

    // drain sequencer
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WAIT_EMPTY = 2'd1,  // let the pipeline settle
        SEND       = 2'd2
    } rd_state_e;

endpackage

/* sa_feed_if.sv */
`timescale 1ns/1ps
`include "sa_defs.svh"

// skewed operands into the array edge
interface sa_feed_if
    import sa_data_pkg::*, sa_ctrl_pkg::*;
();

    pix_pair_t [`SA_N-1:0] pix;        // column j, delayed j cycles
    wgt_byte_t [`SA_N-1:0] wgt;        // row i, delayed i cycles
    logic      [`SA_N-1:0] row_valid;  // travels with wgt
    logic      [`SA_N-1:0] row_first;
    sa_mode_e              mode;

    modport src (
        output pix, wgt, row_valid, row_first, mode
    );

    modport dst (
        input pix, wgt, row_valid, row_first, mode
    );

endinterface

/* sa_operand_skew.sv */
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_operand_skew
    import sa_data_pkg::*, sa_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  sa_mode_e              mode,
    input  logic                  in_valid,
    input  logic                  in_first,
    input  pix_pair_t [`SA_N-1:0] pixels,
    input  wgt_byte_t [`SA_N-1:0] weights,
    sa_feed_if.src                feed
);

    assign feed.mode = mode;

    ////////////////////////////////////////////////////////////
    // row delay lines, weight plus valid and first
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `SA_N; i++) begin : g_row
        if (i == 0) begin : g_direct
            assign feed.wgt[0]       = weights[0];
            assign feed.row_valid[0] = in_valid;
            assign feed.row_first[0] = in_first;
        end else begin : g_delay
            wgt_byte_t w_sr [i];
            logic      v_sr [i];
            logic      f_sr [i];

            always_ff @(posedge clk) begin
                w_sr[0] <= weights[i];
                for (int k = 1; k < i; k++) begin
                    w_sr[k] <= w_sr[k-1];
                end
            end

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int k = 0; k < i; k++) begin
                        v_sr[k] <= 1'b0;
                        f_sr[k] <= 1'b0;
                    end
                end else begin
                    v_sr[0] <= in_valid;
                    f_sr[0] <= in_first;
                    for (int k = 1; k < i; k++) begin
                        v_sr[k] <= v_sr[k-1];
                        f_sr[k] <= f_sr[k-1];
                    end
                end
            end

            assign feed.wgt[i]       = w_sr[i-1];
            assign feed.row_valid[i] = v_sr[i-1];
            assign feed.row_first[i] = f_sr[i-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // column delay lines, pixels only
    ////////////////////////////////////////////////////////////

    for (genvar j = 0; j < `SA_N; j++) begin : g_col
        if (j == 0) begin : g_direct
            assign feed.pix[0] = pixels[0];
        end else begin : g_delay
            pix_pair_t p_sr [j];

            always_ff @(posedge clk) begin
                p_sr[0] <= pixels[j];
                for (int k = 1; k < j; k++) begin
                    p_sr[k] <= p_sr[k-1];
                end
            end

            assign feed.pix[j] = p_sr[j-1];
        end
    end

    // a burst start is always a real vector
    a_first_with_valid: assert property (
        @(posedge clk) disable iff (reset) in_first |-> in_valid
    );

endmodule

/* sa_pe.sv */
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_pe
    import sa_data_pkg::*, sa_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  sa_mode_e  mode,
    input  pix_pair_t pix_in,
    input  wgt_byte_t wgt_in,
    input  logic      valid_in,
    input  logic      first_in,
    output pix_pair_t pix_out,
    output wgt_byte_t wgt_out,
    output logic      valid_out,
    output logic      first_out,
    output acc_word_u acc
);

    logic signed [`ACC88_W-1:0] prod88 [2];     // int8 weight x pixel
    logic        [`ACC18_W-1:0] term18 [2][2];  // [weight bit][pixel]
    acc_word_u                  base;
    acc_word_u                  acc_nxt;

    ////////////////////////////////////////////////////////////
    // operand decode and products
    ////////////////////////////////////////////////////////////

    always_comb begin
        logic signed [`PIX_W:0]   pix_s;
        logic signed [7:0]        wgt_s;
        logic        [`ACC18_W-1:0] pix16;
        wgt_s = $signed(wgt_in);
        for (int p = 0; p < 2; p++) begin
            pix_s     = $signed({1'b0, pix_in[p]});   // pixels are unsigned
            prod88[p] = pix_s * wgt_s;
            pix16     = {{(`ACC18_W-`PIX_W){1'b0}}, pix_in[p]};
            for (int w = 0; w < 2; w++) begin
                term18[w][p] = wgt_in[w] ? -pix16 : pix16;  // bit set means -1
            end
        end
    end

    // first starts a new sum
    assign base = first_in ? '0 : acc;

    always_comb begin
        acc_nxt = base;
        case (mode)
            MODE_8X8: begin
                for (int p = 0; p < 2; p++) begin
                    acc_nxt.l88[p] = base.l88[p] + prod88[p];
                end
            end
            MODE_8X1: begin
                for (int w = 0; w < 2; w++) begin
                    for (int p = 0; p < 2; p++) begin
                        acc_nxt.l18[2*w + p] = base.l18[2*w + p] + term18[w][p];
                    end
                end
            end
            default: acc_nxt = base;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            valid_out <= 1'b0;
            first_out <= 1'b0;
        end else begin
            if (valid_in) begin
                acc <= acc_nxt;
            end
            valid_out <= valid_in;   // one hop right
            first_out <= first_in;
        end
    end

    // payload hops, no reset
    always_ff @(posedge clk) begin
        pix_out <= pix_in;           // one hop down
        wgt_out <= wgt_in;
    end

endmodule

/* sa_array.sv */
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_array
    import sa_data_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    sa_feed_if.dst                feed,
    input  logic [`ROW_W-1:0]     row_sel,
    output logic                  busy,
    output acc_word_u [`SA_N-1:0] row_data
);

    // last element sees a vector 2N-2 cycles after the edge
    localparam int PIPE  = 2 * `SA_N - 2;
    localparam int CNT_W = $clog2(PIPE + 1);

    pix_pair_t pix_o   [`SA_N][`SA_N];
    wgt_byte_t wgt_o   [`SA_N][`SA_N];
    logic      valid_o [`SA_N][`SA_N];
    logic      first_o [`SA_N][`SA_N];
    acc_word_u acc_o   [`SA_N][`SA_N];

    logic [CNT_W-1:0] busy_cnt;

    ////////////////////////////////////////////////////////////
    // pe grid, pixels go down, weights go right
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `SA_N; i++) begin : g_r
        for (genvar j = 0; j < `SA_N; j++) begin : g_c
            pix_pair_t pix_i;
            wgt_byte_t wgt_i;
            logic      valid_i;
            logic      first_i;

            if (i == 0) begin : g_top
                assign pix_i = feed.pix[j];
            end else begin : g_mid
                assign pix_i = pix_o[i-1][j];
            end

            if (j == 0) begin : g_left
                assign wgt_i   = feed.wgt[i];
                assign valid_i = feed.row_valid[i];
                assign first_i = feed.row_first[i];
            end else begin : g_inner
                assign wgt_i   = wgt_o[i][j-1];
                assign valid_i = valid_o[i][j-1];
                assign first_i = first_o[i][j-1];
            end

            sa_pe u_pe (
                .clk       (clk),
                .reset     (reset),
                .mode      (feed.mode),
                .pix_in    (pix_i),
                .wgt_in    (wgt_i),
                .valid_in  (valid_i),
                .first_in  (first_i),
                .pix_out   (pix_o[i][j]),
                .wgt_out   (wgt_o[i][j]),
                .valid_out (valid_o[i][j]),
                .first_out (first_o[i][j]),
                .acc       (acc_o[i][j])
            );
        end
    end

    // busy tracks the newest vector through the grid
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (feed.row_valid[0]) begin
            busy_cnt <= CNT_W'(PIPE);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = feed.row_valid[0] || (busy_cnt != '0);

    for (genvar j = 0; j < `SA_N; j++) begin : g_sel
        assign row_data[j] = acc_o[row_sel][j];   // combinational row mux
    end

    a_row_sel_range: assert property (
        @(posedge clk) disable iff (reset) row_sel < `SA_N
    );

    // corner pe updated last cycle, so busy must have covered it
    a_busy_covers_pipe: assert property (
        @(posedge clk) disable iff (reset) valid_o[`SA_N-1][`SA_N-1] |-> $past(busy)
    );

endmodule

/* sa_readout.sv */
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_readout
    import sa_data_pkg::*, sa_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  drain,
    input  logic                  credit_return,
    input  logic                  busy,
    input  acc_word_u [`SA_N-1:0] row_data,
    output logic [`ROW_W-1:0]     row_sel,
    output logic                  out_valid,
    output logic                  out_last,
    output logic [`ROW_W-1:0]     out_row,
    output acc_word_u [`SA_N-1:0] out_data
);

    localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

    rd_state_e          state;
    logic [`ROW_W-1:0]  row_cnt;
    logic [CRED_W-1:0]  credit_cnt;
    logic               send;
    logic               last_row;

    assign send     = (state == SEND) && (credit_cnt != '0);
    assign last_row = (row_cnt == `ROW_W'(`SA_N - 1));
    assign row_sel  = row_cnt;

    ////////////////////////////////////////////////////////////
    // drain fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            row_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    row_cnt <= '0;
                    if (drain) begin
                        state <= WAIT_EMPTY;
                    end
                end
                WAIT_EMPTY: begin
                    if (!busy) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (send) begin
                        if (last_row) begin
                            state <= IDLE;
                        end
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // one credit per beat, one back per return pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CRED_W'(`OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CRED_W'(credit_return) - CRED_W'(send);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= send;
            out_last  <= send && last_row;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data <= row_data;
            out_row  <= row_cnt;
        end
    end

    a_beat_had_credit: assert property (
        @(posedge clk) disable iff (reset) out_valid |-> ($past(credit_cnt) != '0)
    );

    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset) credit_cnt <= CRED_W'(`OUT_CREDITS)
    );

endmodule

/* quant_sa_top.sv */
`timescale 1ns/1ps
`include "sa_defs.svh"

module quant_sa_top
    import sa_data_pkg::*, sa_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mode_init,
    input  logic                  in_valid,
    input  logic                  in_first,
    input  pix_pair_t [`SA_N-1:0] pixels,
    input  wgt_byte_t [`SA_N-1:0] weights,
    input  logic                  drain,
    input  logic                  credit_return,
    output logic                  out_valid,
    output logic                  out_last,
    output logic [`ROW_W-1:0]     out_row,
    output acc_word_u [`SA_N-1:0] out_data
);

    sa_mode_e              mode;
    logic                  busy;
    logic [`ROW_W-1:0]     row_sel;
    acc_word_u [`SA_N-1:0] row_data;

    // mode is sampled during reset and held after
    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= sa_mode_e'(mode_init);
        end
    end

    sa_feed_if feed_if ();

    sa_operand_skew u_skew (
        .clk      (clk),
        .reset    (reset),
        .mode     (mode),
        .in_valid (in_valid),
        .in_first (in_first),
        .pixels   (pixels),
        .weights  (weights),
        .feed     (feed_if)
    );

    sa_array u_array (
        .clk      (clk),
        .reset    (reset),
        .feed     (feed_if),
        .row_sel  (row_sel),
        .busy     (busy),
        .row_data (row_data)
    );

    sa_readout u_readout (
        .clk           (clk),
        .reset         (reset),
        .drain         (drain),
        .credit_return (credit_return),
        .busy          (busy),
        .row_data      (row_data),
        .row_sel       (row_sel),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .out_row       (out_row),
        .out_data      (out_data)
    );

endmodule

/* tb_quant_sa.sv */
`timescale 1ns/1ps
`include "sa_defs.svh"

module tb_quant_sa
    import sa_data_pkg::*, sa_ctrl_pkg::*;
();

    localparam int RUNS         = 2;
    localparam int BURSTS       = 4;
    localparam int MAX_LEN      = 8;
    localparam int MAX_CDELAY   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_LIMIT  = 2 * `SA_N + `SA_N * (MAX_CDELAY + 3) + 16;
    localparam int BURST_CYCLES = MAX_LEN + 2 * `SA_N + `SA_N * MAX_CDELAY + 8;
    localparam int WATCHDOG_CYCLES = 2 * RUNS * (BURSTS * BURST_CYCLES + RESET_CYCLES) + 100;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  mode_init;
    logic                  in_valid;
    logic                  in_first;
    pix_pair_t [`SA_N-1:0] pixels;
    wgt_byte_t [`SA_N-1:0] weights;
    logic                  drain;
    logic                  credit_return = 1'b0;
    logic                  out_valid;
    logic                  out_last;
    logic [`ROW_W-1:0]     out_row;
    acc_word_u [`SA_N-1:0] out_data;

    sa_mode_e    run_mode;
    acc_word_u   exp_acc [`SA_N][`SA_N];   // expected word per element
    logic [31:0] srng = 32'd16;            // stimulus generator
    logic [31:0] crng = 32'd16;            // credit delay generator
    logic        drained = 1'b0;           // drain requested, last beat not yet seen
    logic        ret_pend = 1'b0;          // return seen, counted next edge
    int          value_errs = 0;
    int          protocol_errs = 0;
    int          timeout_errs = 0;
    int          drains_done = 0;
    int          beats_seen = 0;
    int          returned = 0;
    int          beat_idx = 0;
    int          avail = `OUT_CREDITS;
    int          cdelay = 0;

    always #50 clk = ~clk;

    quant_sa_top quant_sa_top_inst (
        .clk           (clk),
        .reset         (reset),
        .mode_init     (mode_init),
        .in_valid      (in_valid),
        .in_first      (in_first),
        .pixels        (pixels),
        .weights       (weights),
        .drain         (drain),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .out_row       (out_row),
        .out_data      (out_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic log_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        value_errs++;
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
    endtask

    task automatic log_failure(input string msg);
        protocol_errs++;
        $display("failure at %0t ns: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errs, protocol_errs, timeout_errs);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    task automatic update_expected(input logic first, input pix_pair_t [`SA_N-1:0] px,
                                   input wgt_byte_t [`SA_N-1:0] wt);
        int          prod;
        logic [15:0] term;
        for (int i = 0; i < `SA_N; i++) begin
            for (int j = 0; j < `SA_N; j++) begin
                if (first) begin
                    exp_acc[i][j] = '0;
                end
                for (int p = 0; p < 2; p++) begin
                    if (run_mode == MODE_8X8) begin
                        prod = int'($signed(wt[i])) * int'(px[j][p]);  // int8 x uint8
                        exp_acc[i][j].l88[p] = exp_acc[i][j].l88[p] + prod;
                    end else begin
                        for (int w = 0; w < 2; w++) begin
                            term = 16'(px[j][p]);
                            if (wt[i][w]) begin
                                term = -term;   // bit set is -1
                            end
                            exp_acc[i][j].l18[2*w + p] = exp_acc[i][j].l18[2*w + p] + term;
                        end
                    end
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_burst(input int len);
        pix_pair_t [`SA_N-1:0] px;
        wgt_byte_t [`SA_N-1:0] wt;
        for (int k = 0; k < len; k++) begin
            for (int c = 0; c < `SA_N; c++) begin
                srng  = lcg_next(srng);
                px[c] = srng[31:16];
                srng  = lcg_next(srng);
                wt[c] = srng[31:24];
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_first <= (k == 0);   // every burst restarts the sums
            pixels   <= px;
            weights  <= wt;
            update_expected(k == 0, px, wt);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_first <= 1'b0;
    endtask

    task automatic drain_and_wait();
        int start;
        int cycles;
        start = drains_done;
        @(posedge clk);
        drain   <= 1'b1;
        drained = 1'b1;
        @(posedge clk);
        drain <= 1'b0;
        cycles = 0;
        while (drains_done == start && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (drains_done == start) begin
            timeout_errs++;
            $display("drain did not complete within %0d cycles", DRAIN_LIMIT);
        end
    endtask

    task automatic run_in_mode(input sa_mode_e m);
        int len;
        reset     <= 1'b1;
        mode_init <= m;     // latched by the DUT during reset
        drained   = 1'b0;
        run_mode  = m;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int b = 0; b < BURSTS; b++) begin
            srng = lcg_next(srng);
            len  = 3 + int'(srng[31:16] % 16'd6);
            drive_burst(len);
            drain_and_wait();
        end
    endtask

    initial begin
        reset     = 1'b1;
        mode_init = 1'b0;
        in_valid  = 1'b0;
        in_first  = 1'b0;
        pixels    = '0;
        weights   = '0;
        drain     = 1'b0;
        run_in_mode(MODE_8X8);
        run_in_mode(MODE_8X1);
        repeat (4) @(posedge clk);
        print_counts();
        if (value_errs + protocol_errs + timeout_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // credit returns, random gap of 1 to 4 cycles between pulses
    always @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
            returned = 0;
            cdelay   = 0;
        end else if (cdelay > 0) begin
            credit_return <= 1'b0;
            cdelay--;
        end else if (returned < beats_seen) begin
            credit_return <= 1'b1;
            returned++;
            crng   = lcg_next(crng);
            cdelay = 1 + int'(crng[31:30]);
        end else begin
            credit_return <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (reset) begin
            avail      = `OUT_CREDITS;
            ret_pend   = 1'b0;
            beats_seen = 0;
            beat_idx   = 0;
        end else begin
            if (!drained) begin
                assert (!out_valid) else log_mismatch("out_valid", 64'(out_valid), 64'd0);
                assert (!out_last) else log_mismatch("out_last", 64'(out_last), 64'd0);
            end
            if (out_valid) begin
                assert (avail > 0) else log_failure("beat sent while no credit was left");
                assert (out_row == `ROW_W'(beat_idx))
                    else log_mismatch("out_row", 64'(out_row), 64'(beat_idx));
                assert (out_last == (beat_idx == `SA_N - 1))
                    else log_mismatch("out_last", 64'(out_last), 64'(beat_idx == `SA_N - 1));
                for (int j = 0; j < `SA_N; j++) begin
                    assert (out_data[j] == exp_acc[beat_idx][j])
                        else log_mismatch($sformatf("out_data[%0d] row %0d", j, beat_idx),
                                          out_data[j], exp_acc[beat_idx][j]);
                end
                beats_seen++;
                if (beat_idx == `SA_N - 1) begin
                    beat_idx = 0;
                    drains_done++;
                    drained = 1'b0;   // no further beat until the next drain
                end else begin
                    beat_idx++;
                end
            end else begin
                assert (!out_last) else log_failure("out_last high without out_valid");
            end
            assert (beats_seen - returned <= `OUT_CREDITS)
                else log_failure("more beats outstanding than credits");
            avail = avail - int'(out_valid) + int'(ret_pend);
            ret_pend = credit_return;   // DUT takes it on the next rising edge
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        print_counts();
        $display("Done: errors found");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
sa_data_pkg.sv
sa_ctrl_pkg.sv
sa_feed_if.sv
sa_operand_skew.sv
sa_pe.sv
sa_array.sv
sa_readout.sv
quant_sa_top.sv
tb_quant_sa.sv

/* Makefile */
TOP = tb_quant_sa

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
